//--- logic/rv_pkg.sv
package rv_pkg;

    // address and instruction width
    localparam int XLEN = 32;

    // major opcode field sits in inst[6:0]
    localparam int OPCODE_W = 7;

    typedef enum logic [OPCODE_W-1:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_OP_IMM = 7'b0010011,
        OP_OP     = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    function automatic opcode_t opcode_of(logic [XLEN-1:0] inst);
        return opcode_t'(inst[OPCODE_W-1:0]);
    endfunction

    // J-type immediate bits imm[20|10:1|11|19:12] sit in inst[31:12]
    function automatic logic [XLEN-1:0] jal_offset(logic [XLEN-1:0] inst);
        return {
            {(XLEN-20){inst[31]}},
            inst[19:12],
            inst[20],
            inst[30:21],
            1'b0
        };
    endfunction

endpackage

//--- logic/fetch_pkg.sv
package fetch_pkg;

    // one request in flight at most
    typedef enum logic {
        FETCH_IDLE,
        FETCH_WAIT
    } fetch_state_t;

    // coarse class of a fetched word handed to decode
    typedef enum logic [2:0] {
        KIND_ALU,
        KIND_LOAD,
        KIND_STORE,
        KIND_BRANCH,
        KIND_JAL,
        KIND_JALR,
        KIND_SYSTEM,
        KIND_ILLEGAL
    } inst_kind_t;

endpackage

//--- logic/branch_predictor.sv
module branch_predictor
    import rv_pkg::*;
#(
    parameter int PRED_ENTRIES = 16
) (
    input  logic            clk,
    input  logic            reset,
    input  logic [XLEN-1:0] pred_pc,
    input  logic            update_valid,
    input  logic [XLEN-1:0] update_pc,
    input  logic [XLEN-1:0] update_target,
    input  logic            update_taken,
    output logic [XLEN-1:0] pred_next
);

    localparam int IDX_W = $clog2(PRED_ENTRIES);
    localparam int TAG_W = XLEN - IDX_W - 2;
    localparam logic [1:0] WEAK_NT = 2'b01;

    logic [1:0]      counter [PRED_ENTRIES];
    logic            entry_valid [PRED_ENTRIES];
    logic [TAG_W-1:0] tag [PRED_ENTRIES];
    logic [XLEN-1:0] target [PRED_ENTRIES];

    logic [IDX_W-1:0] pred_idx;
    logic [TAG_W-1:0] pred_tag;
    logic             pred_hit;
    logic [IDX_W-1:0] upd_idx;
    logic [TAG_W-1:0] upd_tag;
    logic             upd_hit;
    logic [1:0]       upd_base;
    logic [1:0]       upd_counter;

    // word address picks the entry, the rest is the tag
    assign pred_idx = pred_pc[IDX_W+1:2];
    assign pred_tag = pred_pc[XLEN-1:IDX_W+2];
    assign pred_hit = entry_valid[pred_idx] && tag[pred_idx] == pred_tag;

    assign pred_next = (pred_hit && counter[pred_idx][1]) ? target[pred_idx] : pred_pc + 4;

    assign upd_idx = update_pc[IDX_W+1:2];
    assign upd_tag = update_pc[XLEN-1:IDX_W+2];
    assign upd_hit = entry_valid[upd_idx] && tag[upd_idx] == upd_tag;

    // a new owner of the entry starts from weakly not-taken
    assign upd_base = upd_hit ? counter[upd_idx] : WEAK_NT;

    always_comb begin
        if (update_taken) begin
            upd_counter = (upd_base == 2'b11) ? upd_base : upd_base + 2'd1;
        end else begin
            upd_counter = (upd_base == 2'b00) ? upd_base : upd_base - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PRED_ENTRIES; i++) begin
                counter[i]     <= WEAK_NT;
                entry_valid[i] <= 1'b0;
            end
        end else if (update_valid) begin
            counter[upd_idx]     <= upd_counter;
            entry_valid[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update_valid) begin
            tag[upd_idx]    <= upd_tag;
            target[upd_idx] <= update_target;
        end
    end

endmodule

//--- logic/fetch_unit.sv
module fetch_unit
    import rv_pkg::*;
    import fetch_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            reset,

    // instruction memory
    output logic            mem_req_valid,
    input  logic            mem_req_ready,
    output logic [XLEN-1:0] mem_req_addr,
    input  logic            mem_resp_valid,
    input  logic [XLEN-1:0] mem_resp_addr,
    input  logic [XLEN-1:0] mem_resp_inst,

    // back end steering
    input  logic            redirect_valid,
    input  logic [XLEN-1:0] redirect_pc,

    // predictor lookup
    output logic [XLEN-1:0] pred_pc,
    input  logic [XLEN-1:0] pred_next,

    // queue write side
    output logic            q_wvalid,
    input  logic            q_wready,
    output logic [XLEN-1:0] q_wdata_addr,
    output logic [XLEN-1:0] q_wdata_inst,
    output logic            kill
);

    fetch_state_t    state;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] req_addr;
    logic [XLEN-1:0] last_addr;
    logic [XLEN-1:0] last_inst;

    logic            last_is_jal;
    logic [XLEN-1:0] jal_target;
    logic            jal_hazard;
    logic            req_fire;
    logic            resp_hit;
    logic [XLEN-1:0] next_pc;

    // look at the word accepted last for a jal
    assign last_is_jal = opcode_of(last_inst) == OP_JAL;
    assign jal_target  = last_addr + jal_offset(last_inst);

    // the word after the jal was fetched from the wrong place
    assign jal_hazard = last_is_jal && state == FETCH_WAIT && req_addr != jal_target;

    assign next_pc = last_is_jal ? jal_target + 4 : pred_next;
    assign pred_pc = pc;

    assign mem_req_valid = q_wready;
    assign mem_req_addr  = pc;
    assign req_fire      = mem_req_valid && mem_req_ready;

    // only the response to the pending address counts
    assign resp_hit = state == FETCH_WAIT && mem_resp_valid && mem_resp_addr == req_addr;

    assign q_wvalid     = resp_hit && !jal_hazard && !redirect_valid;
    assign q_wdata_addr = req_addr;
    assign q_wdata_inst = mem_resp_inst;
    assign kill         = redirect_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= FETCH_IDLE;
            pc        <= RESET_PC;
            req_addr  <= '0;
            last_addr <= '0;
            last_inst <= '0;
        end else if (redirect_valid) begin
            // mispredict from the back end wins over everything
            state     <= FETCH_IDLE;
            pc        <= redirect_pc;
            last_addr <= '0;
            last_inst <= '0;
        end else if (jal_hazard) begin
            state     <= FETCH_IDLE;
            pc        <= jal_target;
            last_addr <= '0;
            last_inst <= '0;
        end else if (state == FETCH_WAIT) begin
            if (resp_hit) begin
                last_addr <= mem_resp_addr;
                last_inst <= mem_resp_inst;
                // next request can go out in the same cycle
                if (req_fire) begin
                    req_addr <= pc;
                    pc       <= next_pc;
                end else begin
                    state <= FETCH_IDLE;
                end
            end
        end else begin
            if (req_fire) begin
                state    <= FETCH_WAIT;
                req_addr <= pc;
                pc       <= next_pc;
            end
        end
    end

endmodule

//--- logic/inst_queue.sv
module inst_queue
    import rv_pkg::*;
#(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            kill,

    input  logic            wvalid,
    output logic            wready,
    input  logic [XLEN-1:0] waddr,
    input  logic [XLEN-1:0] winst,

    output logic            rvalid,
    input  logic            rready,
    output logic [XLEN-1:0] raddr,
    output logic [XLEN-1:0] rinst
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT  = (PTR_W+1)'(QUEUE_DEPTH);
    localparam logic [PTR_W:0] LIMIT_COUNT = (PTR_W+1)'(QUEUE_DEPTH - 1);

    logic [XLEN-1:0] addr_mem [QUEUE_DEPTH];
    logic [XLEN-1:0] inst_mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    logic do_write;
    logic do_read;

    // one slot stays free for the response already in flight
    assign wready = count < LIMIT_COUNT;
    assign rvalid = count != '0;

    assign do_write = wvalid && count != FULL_COUNT && !kill;
    assign do_read  = rvalid && rready && !kill;

    assign raddr = addr_mem[rd_ptr];
    assign rinst = inst_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset || kill) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            addr_mem[wr_ptr] <= waddr;
            inst_mem[wr_ptr] <= winst;
        end
    end

endmodule

//--- logic/pre_decode.sv
module pre_decode
    import rv_pkg::*;
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,

    input  logic            in_valid,
    output logic            in_ready,
    input  logic [XLEN-1:0] in_addr,
    input  logic [XLEN-1:0] in_inst,

    output logic            out_valid,
    input  logic            out_ready,
    output logic [XLEN-1:0] out_addr,
    output logic [XLEN-1:0] out_inst,
    output inst_kind_t      out_kind
);

    inst_kind_t in_kind;

    always_comb begin
        case (opcode_of(in_inst))
            OP_OP, OP_OP_IMM, OP_LUI, OP_AUIPC: in_kind = KIND_ALU;
            OP_LOAD:   in_kind = KIND_LOAD;
            OP_STORE:  in_kind = KIND_STORE;
            OP_BRANCH: in_kind = KIND_BRANCH;
            OP_JAL:    in_kind = KIND_JAL;
            OP_JALR:   in_kind = KIND_JALR;
            OP_SYSTEM: in_kind = KIND_SYSTEM;
            default:   in_kind = KIND_ILLEGAL;
        endcase
    end

    // empty or draining this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_addr <= in_addr;
            out_inst <= in_inst;
            out_kind <= in_kind;
        end
    end

endmodule

//--- logic/fetch_top.sv
module fetch_top
    import rv_pkg::*;
    import fetch_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC     = '0,
    parameter int              QUEUE_DEPTH  = 8,
    parameter int              PRED_ENTRIES = 16
) (
    input  logic            clk,
    input  logic            reset,

    output logic            mem_req_valid,
    input  logic            mem_req_ready,
    output logic [XLEN-1:0] mem_req_addr,
    input  logic            mem_resp_valid,
    input  logic [XLEN-1:0] mem_resp_addr,
    input  logic [XLEN-1:0] mem_resp_inst,

    input  logic            redirect_valid,
    input  logic [XLEN-1:0] redirect_pc,

    input  logic            update_valid,
    input  logic [XLEN-1:0] update_pc,
    input  logic [XLEN-1:0] update_target,
    input  logic            update_taken,

    output logic            out_valid,
    input  logic            out_ready,
    output logic [XLEN-1:0] out_addr,
    output logic [XLEN-1:0] out_inst,
    output inst_kind_t      out_kind
);

    logic [XLEN-1:0] pred_pc;
    logic [XLEN-1:0] pred_next;
    logic            q_wvalid;
    logic            q_wready;
    logic [XLEN-1:0] q_wdata_addr;
    logic [XLEN-1:0] q_wdata_inst;
    logic            kill;
    logic            q_rvalid;
    logic            q_rready;
    logic [XLEN-1:0] q_raddr;
    logic [XLEN-1:0] q_rinst;

    branch_predictor #(
        .PRED_ENTRIES(PRED_ENTRIES)
    ) u_pred (
        .clk          (clk),
        .reset        (reset),
        .pred_pc      (pred_pc),
        .update_valid (update_valid),
        .update_pc    (update_pc),
        .update_target(update_target),
        .update_taken (update_taken),
        .pred_next    (pred_next)
    );

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk           (clk),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_resp_valid(mem_resp_valid),
        .mem_resp_addr (mem_resp_addr),
        .mem_resp_inst (mem_resp_inst),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc),
        .pred_pc       (pred_pc),
        .pred_next     (pred_next),
        .q_wvalid      (q_wvalid),
        .q_wready      (q_wready),
        .q_wdata_addr  (q_wdata_addr),
        .q_wdata_inst  (q_wdata_inst),
        .kill          (kill)
    );

    inst_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clk   (clk),
        .reset (reset),
        .kill  (kill),
        .wvalid(q_wvalid),
        .wready(q_wready),
        .waddr (q_wdata_addr),
        .winst (q_wdata_inst),
        .rvalid(q_rvalid),
        .rready(q_rready),
        .raddr (q_raddr),
        .rinst (q_rinst)
    );

    pre_decode u_pdec (
        .clk      (clk),
        .reset    (reset),
        .flush    (redirect_valid),
        .in_valid (q_rvalid),
        .in_ready (q_rready),
        .in_addr  (q_raddr),
        .in_inst  (q_rinst),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_addr (out_addr),
        .out_inst (out_inst),
        .out_kind (out_kind)
    );

endmodule

//--- testbench/fetch_tb.sv
module fetch_tb
    import rv_pkg::*;
    import fetch_pkg::*;
();

    localparam logic [XLEN-1:0] START_PC = 32'h0;

    logic            clk;
    logic            reset;
    logic            mem_req_valid;
    logic            mem_req_ready;
    logic [XLEN-1:0] mem_req_addr;
    logic            mem_resp_valid;
    logic [XLEN-1:0] mem_resp_addr;
    logic [XLEN-1:0] mem_resp_inst;
    logic            redirect_valid;
    logic [XLEN-1:0] redirect_pc;
    logic            update_valid;
    logic [XLEN-1:0] update_pc;
    logic [XLEN-1:0] update_target;
    logic            update_taken;
    logic            out_valid;
    logic            out_ready;
    logic [XLEN-1:0] out_addr;
    logic [XLEN-1:0] out_inst;
    inst_kind_t      out_kind;

    logic [XLEN-1:0] mem [logic [XLEN-1:0]];
    logic [XLEN-1:0] exp_q [$];

    fetch_top #(
        .RESET_PC    (START_PC),
        .QUEUE_DEPTH (8),
        .PRED_ENTRIES(16)
    ) dut (.*);

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    // fill for untouched addresses mixes in every address bit
    function automatic logic [XLEN-1:0] fill_word(logic [XLEN-1:0] a);
        return {a[31:7] ^ a[24:0], OP_OP_IMM};
    endfunction

    function automatic logic [XLEN-1:0] read_word(logic [XLEN-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return fill_word(a);
    endfunction

    // no jal or jalr in filler
    function automatic logic [XLEN-1:0] random_word();
        opcode_t     ops [8];
        logic [2:0]  idx;
        logic [31:0] r;
        ops = '{OP_LUI, OP_AUIPC, OP_BRANCH, OP_LOAD, OP_STORE, OP_OP_IMM, OP_OP, OP_SYSTEM};
        idx = 3'($urandom());
        r = $urandom();
        return {r[31:7], ops[idx]};
    endfunction

    // jal into x1 with the offset in J-type layout
    function automatic logic [XLEN-1:0] encode_jal(logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, OP_JAL};
    endfunction

    function automatic inst_kind_t expected_kind(logic [XLEN-1:0] inst);
        case (inst[6:0])
            OP_OP, OP_OP_IMM, OP_LUI, OP_AUIPC: return KIND_ALU;
            OP_LOAD:   return KIND_LOAD;
            OP_STORE:  return KIND_STORE;
            OP_BRANCH: return KIND_BRANCH;
            OP_JAL:    return KIND_JAL;
            OP_JALR:   return KIND_JALR;
            OP_SYSTEM: return KIND_SYSTEM;
            default:   return KIND_ILLEGAL;
        endcase
    endfunction

    task automatic abort_run(string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    // memory model answers one cycle after each accepted request
    initial begin
        bit              seen;
        logic [XLEN-1:0] a;
        mem_resp_valid = 1'b0;
        mem_resp_addr  = '0;
        mem_resp_inst  = '0;
        forever begin
            @(negedge clk);
            seen = !reset && mem_req_valid && mem_req_ready;
            a    = mem_req_addr;
            @(posedge clk);
            #1;
            mem_resp_valid = seen;
            mem_resp_addr  = a;
            mem_resp_inst  = read_word(a);
        end
    end

    task automatic check_item();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] w;
        a = exp_q.pop_front();
        w = read_word(a);
        assert (out_addr == a) else
            abort_run($sformatf("Mismatch out_addr: got %h expected %h", out_addr, a));
        assert (out_inst == w) else
            abort_run($sformatf("Mismatch out_inst: got %h expected %h", out_inst, w));
        assert (out_kind == expected_kind(w)) else
            abort_run($sformatf("Mismatch out_kind: got %h expected %h",
                                out_kind, expected_kind(w)));
    endtask

    // drain until the scoreboard is empty, then stall the output again
    task automatic collect(bit toggle);
        int idle;
        idle = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            out_ready = toggle ? !out_ready : 1'b1;
            @(negedge clk);
            if (out_valid && out_ready) begin
                check_item();
                idle = 0;
            end else begin
                idle++;
                if (idle >= 200) begin
                    abort_run("Timeout: no output transfer within 200 cycles");
                end
            end
        end
        @(posedge clk);
        #1;
        out_ready = 1'b0;
    endtask

    task automatic expect_run(logic [XLEN-1:0] start, int n);
        for (int i = 0; i < n; i++) begin
            exp_q.push_back(start + 32'(4 * i));
        end
    endtask

    task automatic redirect_to(logic [XLEN-1:0] pc);
        @(posedge clk);
        #1;
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        @(posedge clk);
        #1;
        redirect_valid = 1'b0;
    endtask

    task automatic train(logic [XLEN-1:0] pc, logic [XLEN-1:0] target, bit taken);
        @(posedge clk);
        #1;
        update_valid  = 1'b1;
        update_pc     = pc;
        update_target = target;
        update_taken  = taken;
        @(posedge clk);
        #1;
        update_valid = 1'b0;
    endtask

    task automatic run_sequential();
        @(negedge clk);
        assert (out_valid == 1'b0) else
            abort_run($sformatf("Mismatch out_valid: got %h expected %h", out_valid, 1'b0));
        expect_run(START_PC, 12);
        collect(1'b0);
    endtask

    task automatic run_backpressure();
        // queue fills and fetch stalls
        repeat (30) @(posedge clk);
        @(negedge clk);
        assert (mem_req_valid == 1'b0) else
            abort_run($sformatf("Mismatch mem_req_valid: got %h expected %h",
                                mem_req_valid, 1'b0));
        expect_run(START_PC + 32'h30, 20);
        collect(1'b1);
    endtask

    task automatic run_jal();
        redirect_to(32'hf8);
        exp_q = '{32'hf8, 32'hfc, 32'h100, 32'h140, 32'h144, 32'h148};
        collect(1'b0);
        redirect_to(32'h1f8);
        exp_q = '{32'h1f8, 32'h1fc, 32'h200, 32'h180, 32'h184, 32'h188};
        collect(1'b0);
    endtask

    task automatic run_redirect();
        redirect_to(32'h400);
        expect_run(32'h400, 5);
        collect(1'b0);
        // older words still sit in the queue here
        redirect_to(32'h600);
        expect_run(32'h600, 8);
        collect(1'b0);
    endtask

    task automatic run_prediction();
        train(32'h800, 32'h900, 1'b1);
        train(32'h800, 32'h900, 1'b1);
        redirect_to(32'h800);
        exp_q = '{32'h800, 32'h900, 32'h904};
        collect(1'b0);
        train(32'h800, 32'h900, 1'b0);
        train(32'h800, 32'h900, 1'b0);
        redirect_to(32'h800);
        exp_q = '{32'h800, 32'h804, 32'h808};
        collect(1'b0);
    endtask

    initial begin
        reset          = 1'b1;
        mem_req_ready  = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        update_valid   = 1'b0;
        update_pc      = '0;
        update_target  = '0;
        update_taken   = 1'b0;
        out_ready      = 1'b0;
        void'($urandom(32'h4c13));
        for (int i = 0; i < 64; i++) begin
            mem[32'(4 * i)] = random_word();
        end
        mem[32'h100] = encode_jal(21'h40);
        mem[32'h200] = encode_jal(21'h1fff80);
        mem[32'h800] = {25'h00a5c, OP_BRANCH};
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        run_sequential();
        run_backpressure();
        run_jal();
        run_redirect();
        run_prediction();
        $display("Regression passed");
        $finish;
    end

endmodule

//--- sim.f
logic/rv_pkg.sv
logic/fetch_pkg.sv
logic/branch_predictor.sv
logic/fetch_unit.sv
logic/inst_queue.sv
logic/pre_decode.sv
logic/fetch_top.sv
testbench/fetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f sim.f --top-module fetch_tb -o Vfetch_tb
./obj_dir/Vfetch_tb | tee sim.log

if grep -q "Regression passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
